// File: hdl/cache_pkg.sv
package cache_pkg;

  ////////////////////////////////////////////////////////////
  // Address geometry
  ////////////////////////////////////////////////////////////

  // Byte address width of a request
  localparam int addr_w = 48;

  // A 64-byte block leaves 6 offset bits below the block address
  localparam int offset_w = 6;

  // Width of the block address, which is the byte address with the offset dropped
  localparam int block_w = addr_w - offset_w;

  typedef logic [block_w-1:0] block_addr_t;

  ////////////////////////////////////////////////////////////
  // Statistics counters
  ////////////////////////////////////////////////////////////

  // All counters wrap at this width
  localparam int count_w = 16;

  typedef logic [count_w-1:0] count_t;

  ////////////////////////////////////////////////////////////
  // Replacement policy
  ////////////////////////////////////////////////////////////

  typedef logic policy_t;

  // FIFO keeps a set untouched on a hit, LRU promotes the hit way
  localparam policy_t policy_fifo = 1'b0;
  localparam policy_t policy_lru = 1'b1;

  // Default L1 geometry of 8 sets by 4 ways (2 KiB)
  localparam int l1_sets_default = 8;
  localparam int l1_ways_default = 4;

  // Default L2 geometry of 16 sets by 8 ways (8 KiB)
  localparam int l2_sets_default = 16;
  localparam int l2_ways_default = 8;

endpackage

// File: hdl/cache_level.sv
`timescale 1ns/100ps

// Tag store of one set-associative cache level
module cache_level #(
  parameter int num_sets = cache_pkg::l1_sets_default,
  parameter int num_ways = cache_pkg::l1_ways_default
) (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::policy_t     policy,
  input  cache_pkg::block_addr_t block_addr,
  input  logic                   lookup,
  input  logic                   update,
  output logic                   hit
);

  // The set count is a power of two, so the index is a plain bit slice
  localparam int set_w = $clog2(num_sets);
  // A single way still needs one bit to hold its index
  localparam int way_w = (num_ways > 1) ? $clog2(num_ways) : 1;
  localparam int tag_w = cache_pkg::block_w - set_w;

  // Way 0 is always the newest (FIFO) or most recently used (LRU) entry
  logic [tag_w-1:0]    tag_mem [num_sets][num_ways];
  logic [num_ways-1:0] valid_q [num_sets];

  logic [set_w-1:0] set_idx;
  logic [tag_w-1:0] tag_in;

  logic             match_any;
  logic [way_w-1:0] match_way;

  logic             hit_q;
  logic [way_w-1:0] hit_way_q;

  // Set when the update edge has to rewrite the indexed set
  logic             shift_en;
  // Deepest way that takes part in the shift
  logic [way_w-1:0] last_way;

  ////////////////////////////////////////////////////////////
  // Address split and tag compare
  ////////////////////////////////////////////////////////////

  // Low bits of the block address pick the set, the rest is the tag
  assign set_idx = block_addr[set_w-1:0];
  assign tag_in  = block_addr[cache_pkg::block_w-1:set_w];

  // A tag sits in at most one way of a set, so the match order does not matter
  always_comb begin
    match_any = 1'b0;
    match_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (valid_q[set_idx][w] && (tag_mem[set_idx][w] == tag_in)) begin
        match_any = 1'b1;
        match_way = way_w'(w);
      end
    end
  end

  // Hit flag and hit way are captured on the lookup edge
  always_ff @(posedge clk) begin
    if (reset) begin
      hit_q <= 1'b0;
    end else if (lookup) begin
      hit_q <= match_any;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup) begin
      hit_way_q <= match_way;
    end
  end

  assign hit = hit_q;

  ////////////////////////////////////////////////////////////
  // Replacement update
  ////////////////////////////////////////////////////////////

  // A miss always inserts, an LRU hit promotes, a FIFO hit leaves the set alone
  assign shift_en = update && (!hit_q || (policy == cache_pkg::policy_lru));

  // On a miss the whole set shifts and the last way falls off the end
  // On an LRU hit only the ways in front of the hit way move down
  assign last_way = hit_q ? hit_way_q : way_w'(num_ways - 1);

  // Tag storage carries no reset, the valid bits guard it
  always_ff @(posedge clk) begin
    if (shift_en) begin
      for (int w = 1; w < num_ways; w++) begin
        if (w <= int'(last_way)) begin
          tag_mem[set_idx][w] <= tag_mem[set_idx][w-1];
        end
      end
      // The accessed tag always ends up in front
      tag_mem[set_idx][0] <= tag_in;
    end
  end

  // Valid bits travel with their tags so the valid ways stay a prefix of the set
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= '0;
      end
    end else if (shift_en) begin
      for (int w = 1; w < num_ways; w++) begin
        if (w <= int'(last_way)) begin
          valid_q[set_idx][w] <= valid_q[set_idx][w-1];
        end
      end
      valid_q[set_idx][0] <= 1'b1;
    end
  end

endmodule

// File: hdl/cache_controller.sv
`timescale 1ns/100ps

// Blocking access sequencer, one request in flight at a time
module cache_controller (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_valid,
  input  logic                          req_write,
  input  logic [cache_pkg::addr_w-1:0]  req_addr,
  output logic                          req_ready,
  output logic                          resp_valid,
  output logic                          resp_l1_hit,
  output logic                          resp_l2_hit,
  input  logic                          resp_ready,
  output cache_pkg::block_addr_t        block_addr,
  output logic                          l1_lookup,
  output logic                          l1_update,
  output logic                          l2_lookup,
  output logic                          l2_update,
  input  logic                          l1_hit,
  input  logic                          l2_hit,
  output logic                          l1_event,
  output logic                          l2_event,
  output logic                          write_event
);

  typedef enum logic [2:0] {
    st_idle,
    st_l1_lookup,
    st_l1_update,
    st_l2_lookup,
    st_l2_update,
    st_respond
  } state_t;

  state_t state_q;

  // Registered handshake outputs
  logic ready_q;
  logic resp_valid_q;
  logic l1_hit_q;
  logic l2_hit_q;

  // Request held for the whole access
  cache_pkg::block_addr_t block_q;
  logic                   write_q;

  logic accept;

  // ready_q is only ever high in idle, so it alone qualifies the transfer
  assign accept = ready_q && req_valid;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q      <= st_idle;
      ready_q      <= 1'b0;
      resp_valid_q <= 1'b0;
      l1_hit_q     <= 1'b0;
      l2_hit_q     <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          // Comes up one cycle after reset, drops on the accepting edge
          ready_q <= !accept;
          if (accept) begin
            l1_hit_q <= 1'b0;
            l2_hit_q <= 1'b0;
            state_q  <= st_l1_lookup;
          end
        end
        st_l1_lookup: begin
          state_q <= st_l1_update;
        end
        st_l1_update: begin
          // L2 is only visited when L1 misses
          l1_hit_q <= l1_hit;
          state_q  <= l1_hit ? st_respond : st_l2_lookup;
        end
        st_l2_lookup: begin
          state_q <= st_l2_update;
        end
        st_l2_update: begin
          l2_hit_q <= l2_hit;
          state_q  <= st_respond;
        end
        st_respond: begin
          // One edge to raise the response, then wait for the consumer
          if (!resp_valid_q) begin
            resp_valid_q <= 1'b1;
          end else if (resp_ready) begin
            resp_valid_q <= 1'b0;
            ready_q      <= 1'b1;
            state_q      <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // Offset bits are dropped here, the levels only see block addresses
  always_ff @(posedge clk) begin
    if (accept) begin
      block_q <= req_addr[cache_pkg::addr_w-1:cache_pkg::offset_w];
      write_q <= req_write;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign req_ready   = ready_q;
  assign resp_valid  = resp_valid_q;
  assign resp_l1_hit = l1_hit_q;
  assign resp_l2_hit = l2_hit_q;

  assign block_addr = block_q;

  assign l1_lookup = (state_q == st_l1_lookup);
  assign l1_update = (state_q == st_l1_update);
  assign l2_lookup = (state_q == st_l2_lookup);
  assign l2_update = (state_q == st_l2_update);

  // Statistics strobes share the update cycle, when the hit flags are valid
  assign l1_event = (state_q == st_l1_update);
  assign l2_event = (state_q == st_l2_update);

  // Write-through, so every write op is counted once, at the L1 update
  assign write_event = (state_q == st_l1_update) && write_q;

endmodule

// File: hdl/cache_stats.sv
`timescale 1ns/100ps

// Per-level access, hit, miss and write counters
module cache_stats (
  input  logic              clk,
  input  logic              reset,
  input  logic              l1_event,
  input  logic              l2_event,
  input  logic              write_event,
  input  logic              l1_hit,
  input  logic              l2_hit,
  output cache_pkg::count_t l1_accesses,
  output cache_pkg::count_t l1_hits,
  output cache_pkg::count_t l1_misses,
  output cache_pkg::count_t l1_writes,
  output cache_pkg::count_t l2_accesses,
  output cache_pkg::count_t l2_hits,
  output cache_pkg::count_t l2_misses,
  output cache_pkg::count_t l2_writes
);

  // Counters wrap naturally at count_w
  always_ff @(posedge clk) begin
    if (reset) begin
      l1_accesses <= '0;
      l1_hits     <= '0;
      l1_misses   <= '0;
      l1_writes   <= '0;
      l2_accesses <= '0;
      l2_hits     <= '0;
      l2_misses   <= '0;
      l2_writes   <= '0;
    end else begin
      // Every L1 access is either a hit or a miss
      if (l1_event) begin
        l1_accesses <= l1_accesses + 1'b1;
        if (l1_hit) begin
          l1_hits <= l1_hits + 1'b1;
        end else begin
          l1_misses <= l1_misses + 1'b1;
        end
      end
      // L2 only sees the accesses that missed L1
      if (l2_event) begin
        l2_accesses <= l2_accesses + 1'b1;
        if (l2_hit) begin
          l2_hits <= l2_hits + 1'b1;
        end else begin
          l2_misses <= l2_misses + 1'b1;
        end
      end
      // A write goes through to both levels whatever the hit outcome
      if (write_event) begin
        l1_writes <= l1_writes + 1'b1;
        l2_writes <= l2_writes + 1'b1;
      end
    end
  end

endmodule

// File: hdl/cache_top.sv
`timescale 1ns/100ps

// Two-level tag simulator, L1 first and L2 on an L1 miss
module cache_top #(
  parameter int l1_sets = cache_pkg::l1_sets_default,
  parameter int l1_ways = cache_pkg::l1_ways_default,
  parameter int l2_sets = cache_pkg::l2_sets_default,
  parameter int l2_ways = cache_pkg::l2_ways_default
) (
  input  logic                         clk,
  input  logic                         reset,
  input  cache_pkg::policy_t           policy,
  input  logic                         req_valid,
  input  logic                         req_write,
  input  logic [cache_pkg::addr_w-1:0] req_addr,
  output logic                         req_ready,
  output logic                         resp_valid,
  output logic                         resp_l1_hit,
  output logic                         resp_l2_hit,
  input  logic                         resp_ready,
  output cache_pkg::count_t            l1_accesses,
  output cache_pkg::count_t            l1_hits,
  output cache_pkg::count_t            l1_misses,
  output cache_pkg::count_t            l1_writes,
  output cache_pkg::count_t            l2_accesses,
  output cache_pkg::count_t            l2_hits,
  output cache_pkg::count_t            l2_misses,
  output cache_pkg::count_t            l2_writes
);

  // Both levels index with the same latched block address
  cache_pkg::block_addr_t block_addr;

  logic l1_lookup;
  logic l1_update;
  logic l2_lookup;
  logic l2_update;
  logic l1_hit;
  logic l2_hit;

  logic l1_event;
  logic l2_event;
  logic write_event;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  cache_controller ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_addr    (req_addr),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .resp_l1_hit (resp_l1_hit),
    .resp_l2_hit (resp_l2_hit),
    .resp_ready  (resp_ready),
    .block_addr  (block_addr),
    .l1_lookup   (l1_lookup),
    .l1_update   (l1_update),
    .l2_lookup   (l2_lookup),
    .l2_update   (l2_update),
    .l1_hit      (l1_hit),
    .l2_hit      (l2_hit),
    .l1_event    (l1_event),
    .l2_event    (l2_event),
    .write_event (write_event)
  );

  ////////////////////////////////////////////////////////////
  // Tag stores
  ////////////////////////////////////////////////////////////

  // Policy is held steady while idle, so both levels see the accepted value
  cache_level #(
    .num_sets (l1_sets),
    .num_ways (l1_ways)
  ) l1_i (
    .clk        (clk),
    .reset      (reset),
    .policy     (policy),
    .block_addr (block_addr),
    .lookup     (l1_lookup),
    .update     (l1_update),
    .hit        (l1_hit)
  );

  cache_level #(
    .num_sets (l2_sets),
    .num_ways (l2_ways)
  ) l2_i (
    .clk        (clk),
    .reset      (reset),
    .policy     (policy),
    .block_addr (block_addr),
    .lookup     (l2_lookup),
    .update     (l2_update),
    .hit        (l2_hit)
  );

  // Hit flags go straight from the levels, they are valid during the update cycle
  cache_stats stats_i (
    .clk         (clk),
    .reset       (reset),
    .l1_event    (l1_event),
    .l2_event    (l2_event),
    .write_event (write_event),
    .l1_hit      (l1_hit),
    .l2_hit      (l2_hit),
    .l1_accesses (l1_accesses),
    .l1_hits     (l1_hits),
    .l1_misses   (l1_misses),
    .l1_writes   (l1_writes),
    .l2_accesses (l2_accesses),
    .l2_hits     (l2_hits),
    .l2_misses   (l2_misses),
    .l2_writes   (l2_writes)
  );

endmodule

// File: dv/cache_checker.sv
`timescale 1ns/100ps

// Protocol and counter properties of cache_top
module cache_checker (
  input logic              clk,
  input logic              reset,
  input logic              req_ready,
  input logic              resp_valid,
  input logic              resp_ready,
  input logic              resp_l1_hit,
  input logic              resp_l2_hit,
  input cache_pkg::count_t l1_accesses,
  input cache_pkg::count_t l1_hits,
  input cache_pkg::count_t l1_misses,
  input cache_pkg::count_t l1_writes,
  input cache_pkg::count_t l2_accesses,
  input cache_pkg::count_t l2_hits,
  input cache_pkg::count_t l2_misses,
  input cache_pkg::count_t l2_writes
);

  // All eight counters side by side so one property covers them
  cache_pkg::count_t counters [8];

  assign counters[0] = l1_accesses;
  assign counters[1] = l1_hits;
  assign counters[2] = l1_misses;
  assign counters[3] = l1_writes;
  assign counters[4] = l2_accesses;
  assign counters[5] = l2_hits;
  assign counters[6] = l2_misses;
  assign counters[7] = l2_writes;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // The controller is blocking, so it never offers a slot while a response waits
  ready_vs_resp_a: assert property (@(posedge clk) disable iff (reset)
    !(req_ready && resp_valid))
    else $error("req_ready and resp_valid are high together");

  // A pending response stays up until the consumer takes it
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && !resp_ready) |=> resp_valid)
    else $error("resp_valid dropped before resp_ready");

  // L2 is only visited after an L1 miss
  hit_flags_a: assert property (@(posedge clk) disable iff (reset)
    !(resp_l1_hit && resp_l2_hit))
    else $error("resp_l2_hit is high together with resp_l1_hit");

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 8; i++) begin : g_monotonic
    counter_monotonic_a: assert property (@(posedge clk) disable iff (reset)
      counters[i] >= $past(counters[i]))
      else $error("counter %0d decreased outside of reset", i);
  end

endmodule

bind cache_top cache_checker checker_i (
  .clk         (clk),
  .reset       (reset),
  .req_ready   (req_ready),
  .resp_valid  (resp_valid),
  .resp_ready  (resp_ready),
  .resp_l1_hit (resp_l1_hit),
  .resp_l2_hit (resp_l2_hit),
  .l1_accesses (l1_accesses),
  .l1_hits     (l1_hits),
  .l1_misses   (l1_misses),
  .l1_writes   (l1_writes),
  .l2_accesses (l2_accesses),
  .l2_hits     (l2_hits),
  .l2_misses   (l2_misses),
  .l2_writes   (l2_writes)
);

// File: dv/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

  localparam int clk_period = 40;
  localparam int l1_sets = cache_pkg::l1_sets_default;
  localparam int l1_ways = cache_pkg::l1_ways_default;
  localparam int l2_sets = cache_pkg::l2_sets_default;
  localparam int l2_ways = cache_pkg::l2_ways_default;

  // The request count over all tests bounds the run length
  localparam int total_requests = 6 + 4 + 7 + 8 + 5 + 200;
  localparam int timeout_cycles = total_requests * 20;

  logic clk;
  logic reset;
  cache_pkg::policy_t policy;
  logic req_valid;
  logic req_write;
  logic [cache_pkg::addr_w-1:0] req_addr;
  logic req_ready;
  logic resp_valid;
  logic resp_l1_hit;
  logic resp_l2_hit;
  logic resp_ready;
  cache_pkg::count_t l1_accesses;
  cache_pkg::count_t l1_hits;
  cache_pkg::count_t l1_misses;
  cache_pkg::count_t l1_writes;
  cache_pkg::count_t l2_accesses;
  cache_pkg::count_t l2_hits;
  cache_pkg::count_t l2_misses;
  cache_pkg::count_t l2_writes;

  int errors;
  int checks;
  // Counts rising edges from time 0
  int cycle_count;
  logic [31:0] lcg_state;

  // Reference tag stores with L1 at index 0 and L2 at index 1
  // Way 0 is the front of each set
  cache_pkg::block_addr_t ref_tag [2][16][8];
  logic ref_valid [2][16][8];
  // Expected counters in port order from L1 accesses to L2 writes
  int exp_cnt [8];

  cache_top #(
    .l1_sets (l1_sets),
    .l1_ways (l1_ways),
    .l2_sets (l2_sets),
    .l2_ways (l2_ways)
  ) dut_i (
    .clk         (clk),
    .reset       (reset),
    .policy      (policy),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_addr    (req_addr),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .resp_l1_hit (resp_l1_hit),
    .resp_l2_hit (resp_l2_hit),
    .resp_ready  (resp_ready),
    .l1_accesses (l1_accesses),
    .l1_hits     (l1_hits),
    .l1_misses   (l1_misses),
    .l1_writes   (l1_writes),
    .l2_accesses (l2_accesses),
    .l2_hits     (l2_hits),
    .l2_misses   (l2_misses),
    .l2_writes   (l2_writes)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Only read at falling edges where it is stable
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Watchdog that ends a run which hangs
  initial begin
    #(timeout_cycles * clk_period);
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
  endfunction

  task automatic compare_value(input string test, input string what, input int expected,
                               input int actual);
    checks++;
    assert (expected == actual) else begin
      errors++;
      $display("error %s %s: expected %0d actual %0d", test, what, expected, actual);
    end
  endtask

  // One level of the reference where a miss inserts at the front and an LRU hit promotes
  task automatic model_level(input int lvl, input cache_pkg::block_addr_t block,
                             output logic hit);
    int sets;
    int ways;
    int set_idx;
    int hit_way;
    int last;
    sets = (lvl == 0) ? l1_sets : l2_sets;
    ways = (lvl == 0) ? l1_ways : l2_ways;
    set_idx = int'(block % cache_pkg::block_addr_t'(sets));
    hit_way = -1;
    for (int w = 0; w < ways; w++) begin
      if (ref_valid[lvl][set_idx][w] && ref_tag[lvl][set_idx][w] == block) begin
        hit_way = w;
      end
    end
    hit = (hit_way >= 0);
    // A FIFO hit leaves the set as it is
    if (!hit || policy == cache_pkg::policy_lru) begin
      last = hit ? hit_way : ways - 1;
      for (int w = last; w > 0; w--) begin
        ref_tag[lvl][set_idx][w] = ref_tag[lvl][set_idx][w-1];
        ref_valid[lvl][set_idx][w] = ref_valid[lvl][set_idx][w-1];
      end
      ref_tag[lvl][set_idx][0] = block;
      ref_valid[lvl][set_idx][0] = 1'b1;
    end
  endtask

  // Whole access with write-through counting that visits L2 only on an L1 miss
  task automatic model_access(input cache_pkg::block_addr_t block, input logic write,
                              output logic l1_hit, output logic l2_hit);
    l2_hit = 1'b0;
    model_level(0, block, l1_hit);
    exp_cnt[0]++;
    if (l1_hit) begin
      exp_cnt[1]++;
    end else begin
      exp_cnt[2]++;
      model_level(1, block, l2_hit);
      exp_cnt[4]++;
      if (l2_hit) begin
        exp_cnt[5]++;
      end else begin
        exp_cnt[6]++;
      end
    end
    if (write) begin
      exp_cnt[3]++;
      exp_cnt[7]++;
    end
  endtask

  // Both handshake outputs must stay low while reset is held
  task automatic reset_dut();
    @(negedge clk);
    reset = 1'b1;
    repeat (16) @(negedge clk);
    compare_value("reset", "req_ready", 0, int'(req_ready));
    compare_value("reset", "resp_valid", 0, int'(resp_valid));
    reset = 1'b0;
    for (int l = 0; l < 2; l++) begin
      for (int s = 0; s < 16; s++) begin
        for (int w = 0; w < 8; w++) begin
          ref_valid[l][s][w] = 1'b0;
        end
      end
    end
    for (int i = 0; i < 8; i++) begin
      exp_cnt[i] = 0;
    end
  endtask

  task automatic check_counters(input string test);
    compare_value(test, "l1_accesses", exp_cnt[0], int'(l1_accesses));
    compare_value(test, "l1_hits", exp_cnt[1], int'(l1_hits));
    compare_value(test, "l1_misses", exp_cnt[2], int'(l1_misses));
    compare_value(test, "l1_writes", exp_cnt[3], int'(l1_writes));
    compare_value(test, "l2_accesses", exp_cnt[4], int'(l2_accesses));
    compare_value(test, "l2_hits", exp_cnt[5], int'(l2_hits));
    compare_value(test, "l2_misses", exp_cnt[6], int'(l2_misses));
    compare_value(test, "l2_writes", exp_cnt[7], int'(l2_writes));
  endtask

  // Sends one request and takes its response between two falling edges
  task automatic send(input string test, input int block_num, input logic write,
                      input int stall, output logic l1_hit, output logic l2_hit);
    cache_pkg::block_addr_t block;
    logic exp_l1;
    logic exp_l2;
    int start;
    int waited;
    block = cache_pkg::block_addr_t'(block_num);
    model_access(block, write, exp_l1, exp_l2);
    // A random offset inside the block must not change the outcome
    req_addr = {block, 6'(lcg_next() % 64)};
    req_write = write;
    req_valid = 1'b1;
    waited = 0;
    while (!req_ready && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready) begin
      errors++;
      $display("request of test %s was never accepted", test);
      req_valid = 1'b0;
      return;
    end
    // The next rising edge is the accepting one
    start = cycle_count + 1;
    @(negedge clk);
    req_valid = 1'b0;
    waited = 0;
    while (!resp_valid && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_valid) begin
      errors++;
      $display("no response arrived in test %s", test);
      return;
    end
    l1_hit = resp_l1_hit;
    l2_hit = resp_l2_hit;
    compare_value(test, "resp_l1_hit", int'(exp_l1), int'(resp_l1_hit));
    compare_value(test, "resp_l2_hit", int'(exp_l2), int'(resp_l2_hit));
    compare_value(test, "latency", exp_l1 ? 3 : 5, cycle_count - start);
    // Back-pressure holds the response and its flags
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      checks++;
      assert (resp_valid && resp_l1_hit == exp_l1 && resp_l2_hit == exp_l2) else begin
        errors++;
        $display("response of test %s was not held while resp_ready was low", test);
      end
    end
    resp_ready = 1'b1;
    @(negedge clk);
    resp_ready = 1'b0;
    compare_value(test, "req_ready after response", 1, int'(req_ready));
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  // Six distinct blocks that share no set in either level
  task automatic cold_miss_test();
    logic l1;
    logic l2;
    reset_dut();
    policy = cache_pkg::policy_lru;
    for (int k = 0; k < 6; k++) begin
      send("cold_miss", 100 + 3 * k, 1'b0, 0, l1, l2);
      compare_value("cold_miss", "l1 hit", 0, int'(l1));
      compare_value("cold_miss", "l2 hit", 0, int'(l2));
    end
    compare_value("cold_miss", "l1_misses", 6, int'(l1_misses));
    compare_value("cold_miss", "l2_misses", 6, int'(l2_misses));
    compare_value("cold_miss", "l1_hits", 0, int'(l1_hits));
    compare_value("cold_miss", "l2_hits", 0, int'(l2_hits));
    check_counters("cold_miss");
  endtask

  task automatic l1_reuse_test();
    logic l1;
    logic l2;
    int l1_hits_before;
    int l2_acc_before;
    send("l1_reuse", 200, 1'b0, 0, l1, l2);
    l1_hits_before = int'(l1_hits);
    l2_acc_before = int'(l2_accesses);
    for (int k = 0; k < 3; k++) begin
      send("l1_reuse", 200, 1'b0, 1, l1, l2);
      compare_value("l1_reuse", "l1 hit", 1, int'(l1));
    end
    compare_value("l1_reuse", "l1_hits delta", 3, int'(l1_hits) - l1_hits_before);
    compare_value("l1_reuse", "l2_accesses delta", 0, int'(l2_accesses) - l2_acc_before);
    check_counters("l1_reuse");
  endtask

  // Blocks 13, 21, 29, 37 and 45 all land in L1 set 5
  task automatic fifo_eviction_test();
    logic l1;
    logic l2;
    reset_dut();
    policy = cache_pkg::policy_fifo;
    for (int k = 1; k <= 4; k++) begin
      send("fifo_eviction", 5 + 8 * k, 1'b0, 0, l1, l2);
    end
    send("fifo_eviction", 13, 1'b0, 0, l1, l2);
    compare_value("fifo_eviction", "re-hit oldest l1 hit", 1, int'(l1));
    send("fifo_eviction", 45, 1'b0, 0, l1, l2);
    send("fifo_eviction", 13, 1'b0, 0, l1, l2);
    compare_value("fifo_eviction", "evicted l1 hit", 0, int'(l1));
    compare_value("fifo_eviction", "evicted l2 hit", 1, int'(l2));
    check_counters("fifo_eviction");
  endtask

  // Same sequence as the FIFO test, but the re-hit moves block 13 to the front
  task automatic lru_promotion_test();
    logic l1;
    logic l2;
    reset_dut();
    policy = cache_pkg::policy_lru;
    for (int k = 1; k <= 4; k++) begin
      send("lru_promotion", 5 + 8 * k, 1'b0, 0, l1, l2);
    end
    send("lru_promotion", 13, 1'b0, 0, l1, l2);
    send("lru_promotion", 45, 1'b0, 0, l1, l2);
    send("lru_promotion", 13, 1'b0, 0, l1, l2);
    compare_value("lru_promotion", "promoted l1 hit", 1, int'(l1));
    send("lru_promotion", 21, 1'b0, 0, l1, l2);
    compare_value("lru_promotion", "second oldest l1 hit", 0, int'(l1));
    compare_value("lru_promotion", "second oldest l2 hit", 1, int'(l2));
    check_counters("lru_promotion");
  endtask

  // Latency of every access is checked inside send
  task automatic write_latency_test();
    logic l1;
    logic l2;
    int l1_writes_before;
    int l2_writes_before;
    l1_writes_before = int'(l1_writes);
    l2_writes_before = int'(l2_writes);
    send("write_latency", 300, 1'b1, 0, l1, l2);
    send("write_latency", 300, 1'b0, 0, l1, l2);
    send("write_latency", 300, 1'b1, 2, l1, l2);
    send("write_latency", 301, 1'b1, 0, l1, l2);
    send("write_latency", 301, 1'b0, 1, l1, l2);
    compare_value("write_latency", "l1_writes delta", 3, int'(l1_writes) - l1_writes_before);
    compare_value("write_latency", "l2_writes delta", 3, int'(l2_writes) - l2_writes_before);
    check_counters("write_latency");
  endtask

  // 160 blocks overflow both levels, so evictions happen in L1 and in L2
  task automatic random_stream_test();
    logic l1;
    logic l2;
    int block_num;
    int write;
    int stall;
    reset_dut();
    for (int n = 0; n < 200; n++) begin
      block_num = lcg_next() % 160;
      write = lcg_next() % 2;
      stall = lcg_next() % 5;
      policy = cache_pkg::policy_t'(lcg_next() % 2);
      send("random_stream", block_num, write[0], stall, l1, l2);
    end
    check_counters("random_stream");
  endtask

  initial begin
    reset = 1'b1;
    policy = cache_pkg::policy_fifo;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr = '0;
    resp_ready = 1'b0;
    errors = 0;
    checks = 0;
    lcg_state = 32'd37526;
    cold_miss_test();
    l1_reuse_test();
    fifo_eviction_test();
    lru_promotion_test();
    write_latency_test();
    random_stream_test();
    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
hdl/cache_pkg.sv
hdl/cache_level.sv
hdl/cache_controller.sv
hdl/cache_stats.sv
hdl/cache_top.sv
dv/cache_checker.sv
dv/cache_tb.sv

// File: Makefile
VERILATOR := verilator
TOP       := cache_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
